// ==== tb.f ====
ulpb_pkg.sv
ulpb_node.sv
ulpb_ring.sv
ulpb_node_chk.sv
tb_ulpb_ring.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP = tb_ulpb_ring
FILELIST = tb.f
LOG = sim.log
PASS_MSG = PASS: all tests
RUN_FLAGS = +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_ulpb_ring.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_ulpb_ring;

	localparam int NUM_NODES = 3;
	localparam int NUM_ROWS = 8;
	localparam int MAX_WORDS = 8;
	localparam ulpb_pkg::addr_t NODE_ADDR [NUM_NODES] = '{8'h11, 8'h22, 8'h33};
	localparam ulpb_pkg::addr_t NODE_MASK [NUM_NODES] = '{8'hff, 8'hff, 8'hff};

	// one entry per transaction and -1 for no second source
	localparam int ROW_SRC [NUM_ROWS] = '{0, 0, 0, 0, 1, 0, 2, 1};
	localparam int ROW_SRC2 [NUM_ROWS] = '{-1, -1, -1, -1, 2, -1, -1, -1};
	localparam ulpb_pkg::addr_t ROW_DEST [NUM_ROWS] =
		'{8'h33, 8'h33, 8'h33, 8'h44, 8'h11, 8'h33, 8'h22, 8'h11};
	localparam int ROW_WORDS [NUM_ROWS] = '{1, 2, 3, 1, 2, 2, 3, 1};
	localparam bit ROW_ACK_EN [NUM_ROWS] = '{1, 1, 1, 1, 1, 0, 1, 1};
	localparam bit ROW_OK1 [NUM_ROWS] = '{1, 1, 1, 0, 1, 0, 1, 1};
	localparam bit ROW_OK2 [NUM_ROWS] = '{0, 0, 0, 0, 1, 0, 0, 0};

	logic CLK;
	logic RESET;
	ulpb_pkg::addr_t addr_in [NUM_NODES];
	ulpb_pkg::data_t data_in [NUM_NODES];
	logic pending [NUM_NODES];
	logic req_tx [NUM_NODES];
	logic ack_tx [NUM_NODES];
	logic data_latched [NUM_NODES];
	ulpb_pkg::addr_t addr_out [NUM_NODES];
	ulpb_pkg::data_t data_out [NUM_NODES];
	logic req_rx [NUM_NODES];
	logic ack_rx [NUM_NODES];
	logic tx_fail [NUM_NODES];
	logic tx_success [NUM_NODES];
	logic tx_ack [NUM_NODES];
	logic bus_idle [NUM_NODES];

	// host model state
	ulpb_pkg::data_t tx_words [NUM_NODES][3];
	int tx_count [NUM_NODES];
	int tx_idx [NUM_NODES];
	bit res_seen [NUM_NODES];
	bit res_ok [NUM_NODES];
	bit rx_seen [NUM_NODES];
	bit ack_en;
	ulpb_pkg::addr_t got_addr [NUM_NODES][MAX_WORDS];
	ulpb_pkg::data_t got_data [NUM_NODES][MAX_WORDS];
	int got_cnt [NUM_NODES];
	ulpb_pkg::data_t exp_data [NUM_NODES][MAX_WORDS];
	int exp_cnt [NUM_NODES];

	integer seed;
	int limit;
	int checks;
	int value_errors;
	int other_errors;

	ulpb_ring #(
		.NUM_NODES(NUM_NODES),
		.ADDR_LIST(NODE_ADDR),
		.MASK_LIST(NODE_MASK)
	) uut (
		.CLK(CLK),
		.RESET(RESET),
		.addr_in(addr_in),
		.data_in(data_in),
		.pending(pending),
		.req_tx(req_tx),
		.ack_tx(ack_tx),
		.data_latched(data_latched),
		.addr_out(addr_out),
		.data_out(data_out),
		.req_rx(req_rx),
		.ack_rx(ack_rx),
		.tx_fail(tx_fail),
		.tx_success(tx_success),
		.tx_ack(tx_ack),
		.bus_idle(bus_idle)
	);

	bind ulpb_node ulpb_node_chk u_chk (
		.CLK(CLK),
		.RESET(RESET),
		.req_tx(req_tx),
		.ack_tx(ack_tx),
		.data_latched(data_latched),
		.req_rx(req_rx),
		.ack_rx(ack_rx),
		.tx_fail(tx_fail),
		.tx_success(tx_success)
	);

	initial
	begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	task automatic check_addr(input ulpb_pkg::addr_t got, input ulpb_pkg::addr_t exp,
		input string what);
		checks++;
		if (got !== exp)
		begin
			value_errors++;
			$display("FAIL @%0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_data(input ulpb_pkg::data_t got, input ulpb_pkg::data_t exp,
		input string what);
		checks++;
		if (got !== exp)
		begin
			value_errors++;
			$display("FAIL @%0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input bit got, input bit exp, input string what);
		checks++;
		if (got !== exp)
		begin
			value_errors++;
			$display("FAIL @%0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// two sources share the ring one after the other
	function automatic int timeout_limit();
		int total;
		int one;
		total = 0;
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			one = ulpb_pkg::BIT_CYCLES * (8 + 32 * ROW_WORDS[r] + 4) + ulpb_pkg::RESET_CNT + 20;
			if (ROW_SRC2[r] >= 0)
				one = one * 2;
			total += one;
		end
		return total;
	endfunction

	function automatic int assertion_failures();
		return uut.g_node[0].u_node.u_chk.fail_count + uut.g_node[1].u_node.u_chk.fail_count
			+ uut.g_node[2].u_node.u_chk.fail_count;
	endfunction

	task automatic finish_run;
		int assert_errs;
		assert_errs = assertion_failures();
		$display("checks: %0d, value errors: %0d, other errors: %0d, assertion failures: %0d",
			checks, value_errors, other_errors, assert_errs);
		if (value_errors + other_errors + assert_errs == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	endtask

	task automatic run_hosts;
		for (int i = 0; i < NUM_NODES; i++)
		begin
			// transmit host
			if (ack_tx[i] && req_tx[i])
				req_tx[i] = 1'b0;
			if (data_latched[i])
			begin
				tx_idx[i]++;
				if (tx_idx[i] < tx_count[i])
				begin
					data_in[i] = tx_words[i][tx_idx[i]];
					pending[i] = 1'b1;
				end
				else
					pending[i] = 1'b0;
			end
			if ((tx_success[i] || tx_fail[i]) && !tx_ack[i])
			begin
				if (!res_seen[i])
				begin
					res_seen[i] = 1'b1;
					res_ok[i] = tx_success[i];
				end
				tx_ack[i] = 1'b1;
			end
			else
				tx_ack[i] = 1'b0;

			// receive host
			if (req_rx[i] && !rx_seen[i])
			begin
				if (got_cnt[i] < MAX_WORDS)
				begin
					got_addr[i][got_cnt[i]] = addr_out[i];
					got_data[i][got_cnt[i]] = data_out[i];
					got_cnt[i]++;
				end
				else
				begin
					other_errors++;
					$display("ERROR @%0t: node %0d received more words than fit", $time, i);
				end
			end
			rx_seen[i] = req_rx[i];
			if (req_rx[i] && ack_en)
				ack_rx[i] = 1'b1;
			else if (!req_rx[i])
				ack_rx[i] = 1'b0;
		end
	endtask

	task automatic step_cycle;
		@(posedge CLK);
		#10;
		run_hosts();
	endtask

	task automatic start_source(input int node, input int r);
		int dest;
		int n;
		dest = -1;
		for (int j = 0; j < NUM_NODES; j++)
			if ((j != node) && (ROW_DEST[r] == NODE_ADDR[j]))
				dest = j;
		tx_count[node] = ROW_WORDS[r];
		for (int k = 0; k < ROW_WORDS[r]; k++)
			tx_words[node][k] = $random(seed);
		// without rx ack the second word overruns the receiver
		if (dest >= 0)
		begin
			n = ROW_ACK_EN[r] ? ROW_WORDS[r] : 1;
			for (int k = 0; k < n; k++)
			begin
				exp_data[dest][exp_cnt[dest]] = tx_words[node][k];
				exp_cnt[dest]++;
			end
		end
		tx_idx[node] = 0;
		res_seen[node] = 1'b0;
		res_ok[node] = 1'b0;
		addr_in[node] = ROW_DEST[r];
		data_in[node] = tx_words[node][0];
		pending[node] = 1'b0;
		req_tx[node] = 1'b1;
	endtask

	function automatic bit row_done(input int r);
		bit done;
		done = res_seen[ROW_SRC[r]];
		if (ROW_SRC2[r] >= 0)
			done = done && res_seen[ROW_SRC2[r]];
		for (int i = 0; i < NUM_NODES; i++)
			done = done && bus_idle[i] && !req_tx[i];
		return done;
	endfunction

	function automatic bit any_req_rx();
		bit any;
		any = 1'b0;
		for (int i = 0; i < NUM_NODES; i++)
			any = any || req_rx[i];
		return any;
	endfunction

	task automatic run_row(input int r);
		for (int i = 0; i < NUM_NODES; i++)
		begin
			got_cnt[i] = 0;
			exp_cnt[i] = 0;
		end
		ack_en = ROW_ACK_EN[r];
		start_source(ROW_SRC[r], r);
		if (ROW_SRC2[r] >= 0)
			start_source(ROW_SRC2[r], r);
		while (!row_done(r))
			step_cycle();
		// drain a word left unacknowledged
		ack_en = 1'b1;
		while (any_req_rx())
			step_cycle();
		repeat (2) step_cycle();

		check_flag(res_ok[ROW_SRC[r]], ROW_OK1[r],
			$sformatf("row %0d node %0d tx_success", r, ROW_SRC[r]));
		if (ROW_SRC2[r] >= 0)
			check_flag(res_ok[ROW_SRC2[r]], ROW_OK2[r],
				$sformatf("row %0d node %0d tx_success", r, ROW_SRC2[r]));
		for (int i = 0; i < NUM_NODES; i++)
		begin
			check_flag(bus_idle[i], 1'b1, $sformatf("row %0d node %0d bus_idle", r, i));
			if (got_cnt[i] != exp_cnt[i])
			begin
				other_errors++;
				$display("ERROR @%0t: row %0d node %0d received %0d words instead of %0d",
					$time, r, i, got_cnt[i], exp_cnt[i]);
			end
			for (int k = 0; (k < got_cnt[i]) && (k < exp_cnt[i]); k++)
			begin
				check_addr(got_addr[i][k], ROW_DEST[r],
					$sformatf("row %0d node %0d word %0d addr_out", r, i, k));
				check_data(got_data[i][k], exp_data[i][k],
					$sformatf("row %0d node %0d word %0d data_out", r, i, k));
			end
		end
	endtask

	initial
	begin : watchdog
		int cycles;
		cycles = 0;
		wait (RESET === 1'b1);
		while (cycles < limit)
		begin
			@(posedge CLK);
			cycles++;
		end
		$display("timeout: ring did not finish its transactions within %0d cycles", limit);
		other_errors++;
		finish_run();
	end

	initial
	begin
		seed = 32'hd279a41b;
		checks = 0;
		value_errors = 0;
		other_errors = 0;
		limit = timeout_limit();
		ack_en = 1'b1;
		RESET = 1'b0;
		for (int i = 0; i < NUM_NODES; i++)
		begin
			addr_in[i] = '0;
			data_in[i] = '0;
			pending[i] = 1'b0;
			req_tx[i] = 1'b0;
			ack_rx[i] = 1'b0;
			tx_ack[i] = 1'b0;
			tx_count[i] = 0;
			tx_idx[i] = 0;
			res_seen[i] = 1'b0;
			res_ok[i] = 1'b0;
			rx_seen[i] = 1'b0;
			got_cnt[i] = 0;
			exp_cnt[i] = 0;
		end
		repeat (4) @(posedge CLK);
		#10;
		RESET = 1'b1;
		step_cycle();

		for (int i = 0; i < NUM_NODES; i++)
		begin
			check_flag(bus_idle[i], 1'b1, $sformatf("node %0d bus_idle after reset", i));
			check_flag(ack_tx[i], 1'b0, $sformatf("node %0d ack_tx after reset", i));
			check_flag(req_rx[i], 1'b0, $sformatf("node %0d req_rx after reset", i));
			check_flag(tx_fail[i], 1'b0, $sformatf("node %0d tx_fail after reset", i));
			check_flag(tx_success[i], 1'b0, $sformatf("node %0d tx_success after reset", i));
			check_flag(data_latched[i], 1'b0,
				$sformatf("node %0d data_latched after reset", i));
		end

		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);

		finish_run();
	end

endmodule

`default_nettype wire

// ==== ulpb_node_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module ulpb_node_chk (
	input wire logic CLK,
	input wire logic RESET,
	input wire logic req_tx,
	input wire logic ack_tx,
	input wire logic data_latched,
	input wire logic req_rx,
	input wire logic ack_rx,
	input wire logic tx_fail,
	input wire logic tx_success
);

	int fail_count = 0;

	// node only acknowledges a request the host made
	ack_tx_on_req: assert property (@(posedge CLK) disable iff (!RESET)
		$rose(ack_tx) |-> $past(req_tx))
	else
	begin
		fail_count++;
		$error("ack_tx rose without req_tx");
	end

	tx_result_exclusive: assert property (@(posedge CLK) disable iff (!RESET)
		!(tx_success && tx_fail))
	else
	begin
		fail_count++;
		$error("tx_success and tx_fail both high");
	end

	req_rx_held: assert property (@(posedge CLK) disable iff (!RESET)
		(req_rx && !ack_rx) |=> req_rx)
	else
	begin
		fail_count++;
		$error("req_rx dropped before ack_rx");
	end

	latched_pulse: assert property (@(posedge CLK) disable iff (!RESET)
		data_latched |=> !data_latched)
	else
	begin
		fail_count++;
		$error("data_latched longer than one cycle");
	end

endmodule

`default_nettype wire

// ==== ulpb_ring.sv ====
`timescale 1ns/1ns
`default_nettype none

module ulpb_ring #(
	parameter int NUM_NODES = 3,
	parameter ulpb_pkg::addr_t ADDR_LIST [NUM_NODES] = '{8'h11, 8'h22, 8'h33},
	parameter ulpb_pkg::addr_t MASK_LIST [NUM_NODES] = '{8'hff, 8'hff, 8'hff}
) (
	input wire logic CLK,
	input wire logic RESET,
	input wire ulpb_pkg::addr_t addr_in [NUM_NODES],
	input wire ulpb_pkg::data_t data_in [NUM_NODES],
	input wire logic pending [NUM_NODES],
	input wire logic req_tx [NUM_NODES],
	output logic ack_tx [NUM_NODES],
	output logic data_latched [NUM_NODES],
	output ulpb_pkg::addr_t addr_out [NUM_NODES],
	output ulpb_pkg::data_t data_out [NUM_NODES],
	output logic req_rx [NUM_NODES],
	input wire logic ack_rx [NUM_NODES],
	output logic tx_fail [NUM_NODES],
	output logic tx_success [NUM_NODES],
	input wire logic tx_ack [NUM_NODES],
	output logic bus_idle [NUM_NODES]
);

	logic ring_din [NUM_NODES];
	logic ring_dout [NUM_NODES];
	logic loop_q;

	// closes the ring, half a cycle lets a driven bit reach every node
	always_ff @(negedge CLK or negedge RESET)
	begin
		if (!RESET)
			loop_q <= 1'b1;
		else
			loop_q <= ring_dout[NUM_NODES-1];
	end

	for (genvar i = 0; i < NUM_NODES; i++)
	begin : g_node
		if (i == 0)
		begin : g_head
			assign ring_din[i] = loop_q;
		end
		else
		begin : g_chain
			assign ring_din[i] = ring_dout[i-1];
		end

		ulpb_node #(
			.ADDRESS(ADDR_LIST[i]),
			.ADDRESS_MASK(MASK_LIST[i])
		) u_node (
			.CLK(CLK),
			.RESET(RESET),
			.din(ring_din[i]),
			.dout(ring_dout[i]),
			.addr_in(addr_in[i]),
			.data_in(data_in[i]),
			.pending(pending[i]),
			.req_tx(req_tx[i]),
			.ack_tx(ack_tx[i]),
			.data_latched(data_latched[i]),
			.addr_out(addr_out[i]),
			.data_out(data_out[i]),
			.req_rx(req_rx[i]),
			.ack_rx(ack_rx[i]),
			.tx_fail(tx_fail[i]),
			.tx_success(tx_success[i]),
			.tx_ack(tx_ack[i]),
			.bus_idle(bus_idle[i])
		);
	end

endmodule

`default_nettype wire

// ==== ulpb_node.sv ====
`timescale 1ns/1ns
`default_nettype none

module ulpb_node #(
	parameter ulpb_pkg::addr_t ADDRESS = 8'hab,
	parameter ulpb_pkg::addr_t ADDRESS_MASK = 8'hff
) (
	input wire logic CLK,
	input wire logic RESET,
	input wire logic din,
	output logic dout,
	input wire ulpb_pkg::addr_t addr_in,
	input wire ulpb_pkg::data_t data_in,
	input wire logic pending,
	input wire logic req_tx,
	output logic ack_tx,
	output logic data_latched,
	output ulpb_pkg::addr_t addr_out,
	output ulpb_pkg::data_t data_out,
	output logic req_rx,
	input wire logic ack_rx,
	output logic tx_fail,
	output logic tx_success,
	input wire logic tx_ack,
	output logic bus_idle
);

	ulpb_pkg::bus_state_t state, next_state;
	ulpb_pkg::mode_t mode, next_mode;
	ulpb_pkg::rst_cnt_t reset_cnt, next_reset_cnt;
	ulpb_pkg::bit_cnt_t bit_pos, next_bit_pos;
	logic addr_done, next_addr_done;
	logic out_reg, next_out_reg;
	logic self_reset, next_self_reset;
	logic [1:0] in_buf;
	logic arb_din;

	logic next_ack_tx;
	logic next_req_rx;
	logic next_tx_fail;
	logic next_tx_success;
	logic next_data_latched;
	logic word_ind, next_word_ind;

	// transmit side
	ulpb_pkg::addr_t tx_addr, next_tx_addr;
	ulpb_pkg::data_t tx_data0, next_tx_data0;
	ulpb_pkg::data_t tx_data1, next_tx_data1;
	logic end_of_tx, next_end_of_tx;
	logic tx_done, next_tx_done;
	logic wait_ack, next_wait_ack;

	// receive side
	ulpb_pkg::addr_t next_addr_out;
	ulpb_pkg::data_t next_data_out;
	logic [ulpb_pkg::DATA_W-2:0] rx_buf, next_rx_buf;
	logic rx_done, next_rx_done;
	logic rx_overflow, next_rx_overflow;

	logic addr_bit;
	logic data0_bit;
	logic data1_bit;
	logic buf_diff;
	logic addr_match;

	assign addr_bit = tx_addr[bit_pos[ulpb_pkg::ADDR_IDX_W-1:0]];
	assign data0_bit = tx_data0[bit_pos];
	assign data1_bit = tx_data1[bit_pos];
	// samples differ when a node signals reset or acknowledge
	assign buf_diff = in_buf[0] ^ in_buf[1];
	assign addr_match = ((addr_out ^ ADDRESS) & ADDRESS_MASK) == '0;
	assign bus_idle = (state == ulpb_pkg::bus_idle);

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= ulpb_pkg::bus_idle;
			mode <= ulpb_pkg::mode_idle;
			reset_cnt <= ulpb_pkg::rst_cnt_t'(ulpb_pkg::RESET_CNT - 1);
			bit_pos <= ulpb_pkg::bit_cnt_t'(ulpb_pkg::ADDR_W - 1);
			addr_done <= 1'b0;
			out_reg <= 1'b1;
			self_reset <= 1'b0;
			ack_tx <= 1'b0;
			req_rx <= 1'b0;
			tx_fail <= 1'b0;
			tx_success <= 1'b0;
			data_latched <= 1'b0;
			word_ind <= 1'b0;
			end_of_tx <= 1'b0;
			tx_done <= 1'b0;
			wait_ack <= 1'b0;
			rx_done <= 1'b0;
			rx_overflow <= 1'b0;
		end
		else
		begin
			state <= next_state;
			mode <= next_mode;
			reset_cnt <= next_reset_cnt;
			bit_pos <= next_bit_pos;
			addr_done <= next_addr_done;
			out_reg <= next_out_reg;
			self_reset <= next_self_reset;
			ack_tx <= next_ack_tx;
			req_rx <= next_req_rx;
			tx_fail <= next_tx_fail;
			tx_success <= next_tx_success;
			data_latched <= next_data_latched;
			word_ind <= next_word_ind;
			end_of_tx <= next_end_of_tx;
			tx_done <= next_tx_done;
			wait_ack <= next_wait_ack;
			rx_done <= next_rx_done;
			rx_overflow <= next_rx_overflow;
		end
	end

	always_ff @(posedge CLK)
	begin
		tx_addr <= next_tx_addr;
		tx_data0 <= next_tx_data0;
		tx_data1 <= next_tx_data1;
		addr_out <= next_addr_out;
		data_out <= next_data_out;
		rx_buf <= next_rx_buf;
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
			in_buf <= 2'b00;
		else if ((state == ulpb_pkg::drive1) || (state == ulpb_pkg::drive2))
			in_buf <= {in_buf[0], din};
	end

	// line level before the loop register echoes a request back around the ring
	always_ff @(negedge CLK or negedge RESET)
	begin
		if (!RESET)
			arb_din <= 1'b1;
		else
			arb_din <= din;
	end

	always_comb
	begin
		next_state = state;
		next_mode = mode;
		next_reset_cnt = reset_cnt;
		next_bit_pos = bit_pos;
		next_addr_done = addr_done;
		next_out_reg = out_reg;
		next_self_reset = self_reset;
		next_ack_tx = ack_tx;
		next_req_rx = req_rx;
		next_tx_fail = tx_fail;
		next_tx_success = tx_success;
		next_data_latched = 1'b0;
		next_word_ind = word_ind;
		next_tx_addr = tx_addr;
		next_tx_data0 = tx_data0;
		next_tx_data1 = tx_data1;
		next_end_of_tx = end_of_tx;
		next_tx_done = tx_done;
		next_wait_ack = wait_ack;
		next_addr_out = addr_out;
		next_data_out = data_out;
		next_rx_buf = rx_buf;
		next_rx_done = rx_done;
		next_rx_overflow = rx_overflow;

		if (ack_tx && !req_tx)
			next_ack_tx = 1'b0;
		if (req_rx && ack_rx)
			next_req_rx = 1'b0;
		if (tx_ack)
		begin
			next_tx_fail = 1'b0;
			next_tx_success = 1'b0;
		end

		case (state)
			ulpb_pkg::bus_idle:
			begin
				// line pulled low, by this node or upstream
				if (!dout)
				begin
					if (req_tx && arb_din)
					begin
						next_tx_addr = addr_in;
						next_tx_data0 = data_in;
						next_mode = ulpb_pkg::mode_tx;
						next_ack_tx = 1'b1;
						next_data_latched = 1'b1;
					end
					else
						next_mode = ulpb_pkg::mode_rx;
					next_state = ulpb_pkg::arbi_resolved;
					next_bit_pos = ulpb_pkg::bit_cnt_t'(ulpb_pkg::ADDR_W - 1);
					next_addr_done = 1'b0;
					next_self_reset = 1'b0;
					next_word_ind = 1'b0;
					next_end_of_tx = 1'b0;
					next_tx_done = 1'b0;
					next_wait_ack = 1'b0;
					next_rx_done = 1'b0;
					next_rx_overflow = 1'b0;
				end
			end

			ulpb_pkg::arbi_resolved:
			begin
				next_state = ulpb_pkg::drive1;
				if (mode == ulpb_pkg::mode_tx)
					next_out_reg = addr_bit;
			end

			ulpb_pkg::drive1:
			begin
				next_state = ulpb_pkg::latch1;
				if ((mode == ulpb_pkg::mode_rx) && addr_done && !addr_match)
					next_mode = ulpb_pkg::mode_fwd;
			end

			ulpb_pkg::latch1:
			begin
				next_state = ulpb_pkg::drive2;
				case (mode)
					ulpb_pkg::mode_tx:
					begin
						if (!end_of_tx && tx_done)
							next_out_reg = 1'b1;
					end
					ulpb_pkg::mode_rx:
					begin
						// invert the held bit to force a reset
						if (rx_overflow)
							next_out_reg = !din;
						else if (rx_done)
							next_out_reg = 1'b0;
					end
					default: ;
				endcase
			end

			ulpb_pkg::drive2:
			begin
				next_state = ulpb_pkg::latch2;
				if (mode == ulpb_pkg::mode_tx)
				begin
					if (tx_done)
						next_end_of_tx = 1'b1;
					else if (bit_pos != '0)
						next_bit_pos = bit_pos - 1'b1;
					else
					begin
						next_bit_pos = ulpb_pkg::bit_cnt_t'(ulpb_pkg::DATA_W - 1);
						next_addr_done = 1'b1;
						if (addr_done)
						begin
							// word boundary, refill the idle word register
							if (pending)
							begin
								next_word_ind = !word_ind;
								next_data_latched = 1'b1;
								if (!word_ind)
									next_tx_data1 = data_in;
								else
									next_tx_data0 = data_in;
							end
							else
								next_tx_done = 1'b1;
						end
					end
				end
			end

			ulpb_pkg::latch2:
			begin
				next_reset_cnt = ulpb_pkg::rst_cnt_t'(ulpb_pkg::RESET_CNT - 1);
				case (mode)
					ulpb_pkg::mode_tx:
					begin
						if (self_reset)
							next_state = ulpb_pkg::bus_reset;
						else if (tx_done && !end_of_tx)
						begin
							next_out_reg = 1'b0;
							next_state = ulpb_pkg::drive1;
							if (buf_diff)
							begin
								next_self_reset = 1'b1;
								next_tx_fail = 1'b1;
							end
						end
						else if (tx_done && end_of_tx)
						begin
							next_wait_ack = 1'b1;
							if (!wait_ack)
								next_state = ulpb_pkg::drive1;
							else
							begin
								// second ack bit toggles only if the receiver took the data
								next_state = ulpb_pkg::bus_reset;
								if (buf_diff)
									next_tx_success = 1'b1;
								else
									next_tx_fail = 1'b1;
							end
						end
						else
						begin
							next_state = ulpb_pkg::drive1;
							if (buf_diff)
							begin
								next_self_reset = 1'b1;
								next_tx_fail = 1'b1;
							end
							else if (!addr_done)
								next_out_reg = addr_bit;
							else if (!word_ind)
								next_out_reg = data0_bit;
							else
								next_out_reg = data1_bit;
						end
					end

					ulpb_pkg::mode_rx:
					begin
						if (self_reset)
							next_state = ulpb_pkg::bus_reset;
						else if (buf_diff)
						begin
							if (rx_overflow)
							begin
								next_self_reset = 1'b1;
								next_state = ulpb_pkg::drive1;
							end
							else
							begin
								// end of data, answer with the ack bit
								next_rx_done = 1'b1;
								if (!rx_done)
								begin
									next_out_reg = 1'b1;
									next_state = ulpb_pkg::drive1;
								end
								else
									next_state = ulpb_pkg::bus_reset;
							end
						end
						else
						begin
							next_state = ulpb_pkg::drive1;
							if (bit_pos != '0)
								next_bit_pos = bit_pos - 1'b1;
							else
							begin
								next_addr_done = 1'b1;
								next_bit_pos = ulpb_pkg::bit_cnt_t'(ulpb_pkg::DATA_W - 1);
								if (addr_done)
								begin
									if (req_rx || ack_rx)
										next_rx_overflow = 1'b1;
									else
									begin
										next_data_out = {rx_buf, in_buf[0]};
										next_req_rx = 1'b1;
									end
								end
							end
							if (!addr_done)
								next_addr_out = {addr_out[ulpb_pkg::ADDR_W-2:0], in_buf[0]};
							else
								next_rx_buf = {rx_buf[ulpb_pkg::DATA_W-3:0], in_buf[0]};
						end
					end

					ulpb_pkg::mode_fwd:
					begin
						if (self_reset)
							next_state = ulpb_pkg::bus_reset;
						else
						begin
							next_state = ulpb_pkg::drive1;
							if (buf_diff)
								next_self_reset = 1'b1;
						end
					end

					default:
						next_state = ulpb_pkg::bus_reset;
				endcase
			end

			ulpb_pkg::bus_reset:
			begin
				if (reset_cnt != '0)
					next_reset_cnt = reset_cnt - 1'b1;
				else
				begin
					next_state = ulpb_pkg::bus_idle;
					next_mode = ulpb_pkg::mode_idle;
				end
			end
		endcase
	end

	// own bit or forwarded din
	always_comb
	begin
		dout = din;
		case (state)
			ulpb_pkg::bus_idle:
				dout = !req_tx && din;
			ulpb_pkg::arbi_resolved:
			begin
				if (mode == ulpb_pkg::mode_tx)
					dout = 1'b0;
			end
			ulpb_pkg::drive1:
			begin
				if ((mode == ulpb_pkg::mode_tx) && !wait_ack)
					dout = out_reg;
				else if ((mode == ulpb_pkg::mode_rx) && rx_done)
					dout = out_reg;
			end
			ulpb_pkg::latch1:
			begin
				if ((mode == ulpb_pkg::mode_tx) && !wait_ack && !self_reset)
					dout = out_reg;
				else if ((mode == ulpb_pkg::mode_rx) && rx_done && !self_reset)
					dout = out_reg;
			end
			ulpb_pkg::drive2:
			begin
				if ((mode == ulpb_pkg::mode_tx) && !end_of_tx && tx_done && !self_reset)
					dout = out_reg;
				else if ((mode == ulpb_pkg::mode_rx) && (rx_done || rx_overflow) && !self_reset)
					dout = out_reg;
			end
			ulpb_pkg::latch2:
			begin
				if ((mode == ulpb_pkg::mode_tx) && !end_of_tx && tx_done)
					dout = out_reg;
				else if ((mode == ulpb_pkg::mode_rx) && (rx_done || rx_overflow))
					dout = out_reg;
			end
			// every node pulls high so the ring settles back to idle
			ulpb_pkg::bus_reset:
				dout = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// ==== ulpb_pkg.sv ====
`default_nettype none

package ulpb_pkg;

	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	// cycles spent in bus_reset, and cycles per bus bit
	localparam int RESET_CNT = 4;
	localparam int BIT_CYCLES = 4;

	localparam int BIT_CNT_W = $clog2(DATA_W);
	localparam int ADDR_IDX_W = $clog2(ADDR_W);
	localparam int RST_CNT_W = $clog2(RESET_CNT);

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [BIT_CNT_W-1:0] bit_cnt_t;
	typedef logic [RST_CNT_W-1:0] rst_cnt_t;

	typedef enum logic [2:0] {
		bus_idle,
		arbi_resolved,
		drive1,
		latch1,
		drive2,
		latch2,
		bus_reset
	} bus_state_t;

	typedef enum logic [1:0] {
		mode_idle,
		mode_tx,
		mode_rx,
		mode_fwd
	} mode_t;

endpackage

`default_nettype wire
